//--- logic/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// operand and result width.
`define DATA_WIDTH 32

// pc and data address width.
`define ADDR_WIDTH 32

`define REG_ADDR_WIDTH 5

// data ram depth in words.
`define DMEM_WORDS 256

`endif

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

  // rv32i major opcodes.
  typedef enum logic [6:0] {
    R         = 7'b0110011,
    IMMEDIATE = 7'b0010011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    BRANCH    = 7'b1100011,
    JAL       = 7'b1101111,
    AUIPC     = 7'b0010111
  } opcode_e;

  typedef enum logic {
    BYTE = 1'b0,
    WORD = 1'b1
  } access_size_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_view_t;

  // one instruction word, register view or immediate views.
  typedef union packed {
    r_view_t r;
    i_view_t i;
    s_view_t s;
  } instr_u;

endpackage

`default_nettype wire

//--- logic/alu.sv
`default_nettype none
`include "core_defines.svh"

module alu (
  input  var core_pkg::opcode_e  opcode_i,
  input  logic [2:0]             funct3_i,
  input  logic [6:0]             funct7_i,
  input  logic [`DATA_WIDTH-1:0] a_i,
  input  logic [`DATA_WIDTH-1:0] b_i,
  output logic                   is_zero_o,
  output logic                   is_less_o,
  output logic [`DATA_WIDTH-1:0] result_o
);

  logic [4:0]             shamt;
  logic                   is_sub;
  logic                   is_less_u;
  logic [`DATA_WIDTH-1:0] sra_result;

  assign shamt  = b_i[4:0];
  // funct7 bit 5 selects sub only on register ops.
  assign is_sub = (opcode_i == core_pkg::R) && funct7_i[5];

  assign is_zero_o  = (a_i == b_i);
  assign is_less_o  = ($signed(a_i) < $signed(b_i));
  assign is_less_u  = (a_i < b_i);
  assign sra_result = $signed(a_i) >>> shamt;

  always_comb begin
    result_o = a_i + b_i;
    case (opcode_i)
      core_pkg::R, core_pkg::IMMEDIATE: begin
        case (funct3_i)
          3'b000: result_o = is_sub ? (a_i - b_i) : (a_i + b_i);
          3'b001: result_o = a_i << shamt;
          3'b010: result_o = {{(`DATA_WIDTH-1){1'b0}}, is_less_o};
          3'b011: result_o = {{(`DATA_WIDTH-1){1'b0}}, is_less_u};
          3'b100: result_o = a_i ^ b_i;
          3'b101: result_o = funct7_i[5] ? sra_result : (a_i >> shamt);
          3'b110: result_o = a_i | b_i;
          default: result_o = a_i & b_i;
        endcase
      end
      core_pkg::BRANCH: begin
        result_o = a_i - b_i;
      end
      default: begin
        // loads, stores, jal and auipc all add.
        result_o = a_i + b_i;
      end
    endcase
  end

endmodule : alu

`default_nettype wire

//--- logic/alu_stage.sv
`default_nettype none
`include "core_defines.svh"

module alu_stage (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        valid_i,
  input  logic                        mem_stall_i,
  input  logic [`DATA_WIDTH-1:0]      data_a_i,
  input  logic [`DATA_WIDTH-1:0]      data_b_i,
  input  logic [`ADDR_WIDTH-1:0]      pc_i,
  input  logic [`DATA_WIDTH-1:0]      offset_sign_extend_i,
  input  var core_pkg::instr_u        instruction_i,
  output logic                        alu_wr_en_o,
  output logic [`REG_ADDR_WIDTH-1:0]  wr_reg_o,
  output logic [`DATA_WIDTH-1:0]      data_to_reg_o,
  output logic                        branch_taken_o,
  output logic [`ADDR_WIDTH-1:0]      pc_branch_offset_o,
  output logic                        is_jump_o,
  output logic [`ADDR_WIDTH-1:0]      jump_address_o,
  output logic                        mem_valid_o,
  output logic                        mem_is_load_o,
  output logic                        mem_is_store_o,
  output core_pkg::access_size_e      mem_access_size_o,
  output logic [`DATA_WIDTH-1:0]      mem_alu_result_o,
  output logic [`DATA_WIDTH-1:0]      mem_rs2_data_o,
  output logic [`REG_ADDR_WIDTH-1:0]  mem_wr_reg_o
);

  logic [`DATA_WIDTH-1:0] alu_a;
  logic [`DATA_WIDTH-1:0] alu_b;
  logic [`DATA_WIDTH-1:0] alu_result;
  logic                   is_zero;
  logic                   is_less;
  logic                   is_load_d;
  logic                   is_store_d;
  core_pkg::access_size_e access_size_d;

  always_comb begin
    alu_a          = data_a_i;
    alu_b          = data_b_i;
    is_load_d      = 1'b0;
    is_store_d     = 1'b0;
    is_jump_o      = 1'b0;
    alu_wr_en_o    = 1'b0;
    branch_taken_o = 1'b0;
    // funct3 000 is a byte access, anything else a word.
    access_size_d  = (instruction_i.r.funct3 == 3'b000) ? core_pkg::BYTE : core_pkg::WORD;
    case (instruction_i.r.opcode)
      core_pkg::R: begin
        alu_wr_en_o = valid_i;
      end
      core_pkg::IMMEDIATE: begin
        alu_b       = offset_sign_extend_i;
        alu_wr_en_o = valid_i;
      end
      core_pkg::LOAD: begin
        alu_b     = offset_sign_extend_i;
        is_load_d = 1'b1;
      end
      core_pkg::STORE: begin
        alu_b      = offset_sign_extend_i;
        is_store_d = 1'b1;
      end
      core_pkg::BRANCH: begin
        case (instruction_i.r.funct3)
          3'b000: branch_taken_o = valid_i && is_zero;
          3'b001: branch_taken_o = valid_i && !is_zero;
          3'b100: branch_taken_o = valid_i && is_less;
          3'b101: branch_taken_o = valid_i && !is_less;
          default: branch_taken_o = 1'b0;
        endcase
      end
      core_pkg::JAL: begin
        // link value is pc plus 4.
        alu_a       = pc_i;
        alu_b       = `DATA_WIDTH'd4;
        is_jump_o   = valid_i;
        alu_wr_en_o = valid_i;
      end
      core_pkg::AUIPC: begin
        alu_a       = pc_i;
        alu_b       = offset_sign_extend_i;
        alu_wr_en_o = valid_i;
      end
      default: begin
        alu_wr_en_o = 1'b0;
      end
    endcase
  end

  alu u_alu (
    .opcode_i  (instruction_i.r.opcode),
    .funct3_i  (instruction_i.r.funct3),
    .funct7_i  (instruction_i.r.funct7),
    .a_i       (alu_a),
    .b_i       (alu_b),
    .is_zero_o (is_zero),
    .is_less_o (is_less),
    .result_o  (alu_result)
  );

  assign wr_reg_o           = instruction_i.r.rd;
  assign data_to_reg_o      = alu_result;
  assign pc_branch_offset_o = pc_i + offset_sign_extend_i;
  assign jump_address_o     = pc_i + offset_sign_extend_i;

  // ex/mem control.
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mem_valid_o    <= 1'b0;
      mem_is_load_o  <= 1'b0;
      mem_is_store_o <= 1'b0;
    end else if (!mem_stall_i) begin
      mem_valid_o    <= valid_i && (is_load_d || is_store_d);
      mem_is_load_o  <= valid_i && is_load_d;
      mem_is_store_o <= valid_i && is_store_d;
    end
  end

  // ex/mem payload.
  always_ff @(posedge clk_i) begin
    if (!mem_stall_i) begin
      mem_access_size_o <= access_size_d;
      mem_alu_result_o  <= alu_result;
      mem_rs2_data_o    <= data_b_i;
      mem_wr_reg_o      <= instruction_i.r.rd;
    end
  end

  // a memory op is either a load or a store.
  a_load_store_excl : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    !(mem_is_load_o && mem_is_store_o)
  );

endmodule : alu_stage

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none
`include "core_defines.svh"

module reg_file (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
  output logic [`DATA_WIDTH-1:0]     rs1_data_o,
  output logic [`DATA_WIDTH-1:0]     rs2_data_o,
  input  logic [`REG_ADDR_WIDTH-1:0] dbg_addr_i,
  output logic [`DATA_WIDTH-1:0]     dbg_data_o,
  input  logic                       alu_wr_en_i,
  input  logic [`REG_ADDR_WIDTH-1:0] alu_wr_reg_i,
  input  logic [`DATA_WIDTH-1:0]     alu_wr_data_i,
  input  logic                       ld_wr_en_i,
  input  logic [`REG_ADDR_WIDTH-1:0] ld_wr_reg_i,
  input  logic [`DATA_WIDTH-1:0]     ld_wr_data_i
);

  // x0 has no storage.
  logic [`DATA_WIDTH-1:0] regs [1:31];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (ld_wr_en_i && (ld_wr_reg_i != '0)) begin
        regs[ld_wr_reg_i] <= ld_wr_data_i;
      end
      // alu write is younger, so it lands last.
      if (alu_wr_en_i && (alu_wr_reg_i != '0)) begin
        regs[alu_wr_reg_i] <= alu_wr_data_i;
      end
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
  assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];

endmodule : reg_file

`default_nettype wire

//--- logic/decode_stage.sv
`default_nettype none
`include "core_defines.svh"

module decode_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       issue_valid_i,
  input  var core_pkg::instr_u       issue_instr_i,
  input  logic [`ADDR_WIDTH-1:0]     issue_pc_i,
  input  logic                       mem_stall_i,
  input  logic                       redirect_i,
  output logic [`REG_ADDR_WIDTH-1:0] rs1_addr_o,
  output logic [`REG_ADDR_WIDTH-1:0] rs2_addr_o,
  input  logic [`DATA_WIDTH-1:0]     rs1_data_i,
  input  logic [`DATA_WIDTH-1:0]     rs2_data_i,
  output logic                       ready_o,
  output logic                       ex_valid_o,
  output core_pkg::instr_u           ex_instr_o,
  output logic [`ADDR_WIDTH-1:0]     ex_pc_o,
  output logic [`DATA_WIDTH-1:0]     ex_imm_o,
  output logic [`DATA_WIDTH-1:0]     ex_rs1_data_o,
  output logic [`DATA_WIDTH-1:0]     ex_rs2_data_o
);

  assign ready_o = !mem_stall_i;

  // an instruction offered during a redirect is squashed.
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ex_valid_o <= 1'b0;
    end else if (!mem_stall_i) begin
      ex_valid_o <= issue_valid_i && !redirect_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!mem_stall_i && issue_valid_i) begin
      ex_instr_o <= issue_instr_i;
      ex_pc_o    <= issue_pc_i;
    end
  end

  // immediate format follows the opcode.
  always_comb begin
    case (ex_instr_o.r.opcode)
      core_pkg::STORE: begin
        ex_imm_o = {{(`DATA_WIDTH-12){ex_instr_o.s.imm_hi[6]}},
                    ex_instr_o.s.imm_hi, ex_instr_o.s.imm_lo};
      end
      core_pkg::BRANCH: begin
        ex_imm_o = {{(`DATA_WIDTH-12){ex_instr_o[31]}}, ex_instr_o[7],
                    ex_instr_o[30:25], ex_instr_o[11:8], 1'b0};
      end
      core_pkg::JAL: begin
        ex_imm_o = {{(`DATA_WIDTH-20){ex_instr_o[31]}}, ex_instr_o[19:12],
                    ex_instr_o[20], ex_instr_o[30:21], 1'b0};
      end
      core_pkg::AUIPC: begin
        ex_imm_o = {ex_instr_o[31:12], 12'b0};
      end
      default: begin
        ex_imm_o = {{(`DATA_WIDTH-12){ex_instr_o.i.imm[11]}}, ex_instr_o.i.imm};
      end
    endcase
  end

  // operands are read while the word sits in id/ex.
  assign rs1_addr_o    = ex_instr_o.r.rs1;
  assign rs2_addr_o    = ex_instr_o.r.rs2;
  assign ex_rs1_data_o = rs1_data_i;
  assign ex_rs2_data_o = rs2_data_i;

  // id/ex holds through a load stall.
  a_hold_on_stall : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    mem_stall_i |=> $stable(ex_instr_o)
  );

endmodule : decode_stage

`default_nettype wire

//--- logic/mem_stage.sv
`default_nettype none
`include "core_defines.svh"

module mem_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       mem_valid_i,
  input  logic                       is_load_i,
  input  logic                       is_store_i,
  input  var core_pkg::access_size_e access_size_i,
  input  logic [`ADDR_WIDTH-1:0]     addr_i,
  input  logic [`DATA_WIDTH-1:0]     store_data_i,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_reg_i,
  output logic                       mem_stall_o,
  output logic                       ld_wr_en_o,
  output logic [`REG_ADDR_WIDTH-1:0] ld_wr_reg_o,
  output logic [`DATA_WIDTH-1:0]     ld_wr_data_o
);

  localparam int IdxWidth = $clog2(`DMEM_WORDS);
  localparam int Lanes    = `DATA_WIDTH / 8;

  logic [`DATA_WIDTH-1:0] dmem [`DMEM_WORDS];
  logic [IdxWidth-1:0]    word_idx;
  logic [Lanes-1:0]       byte_en;
  logic [`DATA_WIDTH-1:0] wr_word;
  logic [`DATA_WIDTH-1:0] rd_word;
  logic [7:0]             rd_byte;
  logic                   load_done;
  logic                   store_en;

  assign word_idx = addr_i[IdxWidth+1:2];
  assign store_en = mem_valid_i && is_store_i;

  // byte stores replicate the byte and enable one lane.
  assign byte_en = (access_size_i == core_pkg::WORD) ? {Lanes{1'b1}} :
                   (Lanes'(1) << addr_i[1:0]);
  assign wr_word = (access_size_i == core_pkg::WORD) ? store_data_i :
                   {Lanes{store_data_i[7:0]}};

  // one stall cycle per load, the read happens at its end.
  assign mem_stall_o = mem_valid_i && is_load_i && !load_done;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      load_done <= 1'b0;
    end else begin
      load_done <= mem_stall_o;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < Lanes; b++) begin
      if (store_en && byte_en[b]) begin
        dmem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
      end
    end
    if (mem_stall_o) begin
      rd_word <= dmem[word_idx];
    end
  end

  // ex/mem still holds the load while it writes back.
  assign rd_byte      = rd_word[8*addr_i[1:0] +: 8];
  assign ld_wr_en_o   = load_done;
  assign ld_wr_reg_o  = wr_reg_i;
  assign ld_wr_data_o = (access_size_i == core_pkg::WORD) ? rd_word :
                        {{(`DATA_WIDTH-8){rd_byte[7]}}, rd_byte};

  a_single_stall : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    mem_stall_o |=> !mem_stall_o
  );

endmodule : mem_stage

`default_nettype wire

//--- logic/exec_core.sv
`default_nettype none
`include "core_defines.svh"

module exec_core (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       issue_valid_i,
  input  logic [`DATA_WIDTH-1:0]     issue_instr_i,
  input  logic [`ADDR_WIDTH-1:0]     issue_pc_i,
  output logic                       ready_o,
  output logic                       branch_taken_o,
  output logic [`ADDR_WIDTH-1:0]     branch_target_o,
  output logic                       is_jump_o,
  output logic [`ADDR_WIDTH-1:0]     jump_target_o,
  input  logic [`REG_ADDR_WIDTH-1:0] dbg_reg_addr_i,
  output logic [`DATA_WIDTH-1:0]     dbg_reg_data_o
);

  logic                       ex_valid;
  core_pkg::instr_u           ex_instr;
  logic [`ADDR_WIDTH-1:0]     ex_pc;
  logic [`DATA_WIDTH-1:0]     ex_imm;
  logic [`DATA_WIDTH-1:0]     ex_rs1_data;
  logic [`DATA_WIDTH-1:0]     ex_rs2_data;
  logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [`DATA_WIDTH-1:0]     rs1_data;
  logic [`DATA_WIDTH-1:0]     rs2_data;
  logic                       alu_wr_en;
  logic [`REG_ADDR_WIDTH-1:0] alu_wr_reg;
  logic [`DATA_WIDTH-1:0]     alu_wr_data;
  logic                       mem_valid;
  logic                       mem_is_load;
  logic                       mem_is_store;
  core_pkg::access_size_e     mem_access_size;
  logic [`DATA_WIDTH-1:0]     mem_alu_result;
  logic [`DATA_WIDTH-1:0]     mem_rs2_data;
  logic [`REG_ADDR_WIDTH-1:0] mem_wr_reg;
  logic                       ld_wr_en;
  logic [`REG_ADDR_WIDTH-1:0] ld_wr_reg;
  logic [`DATA_WIDTH-1:0]     ld_wr_data;
  logic                       mem_stall;
  logic                       redirect;

  // any taken control transfer squashes the next issue.
  assign redirect = branch_taken_o || is_jump_o;

  decode_stage u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_instr_i (issue_instr_i),
    .issue_pc_i    (issue_pc_i),
    .mem_stall_i   (mem_stall),
    .redirect_i    (redirect),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .ready_o       (ready_o),
    .ex_valid_o    (ex_valid),
    .ex_instr_o    (ex_instr),
    .ex_pc_o       (ex_pc),
    .ex_imm_o      (ex_imm),
    .ex_rs1_data_o (ex_rs1_data),
    .ex_rs2_data_o (ex_rs2_data)
  );

  reg_file u_reg_file (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rs1_addr_i    (rs1_addr),
    .rs2_addr_i    (rs2_addr),
    .rs1_data_o    (rs1_data),
    .rs2_data_o    (rs2_data),
    .dbg_addr_i    (dbg_reg_addr_i),
    .dbg_data_o    (dbg_reg_data_o),
    .alu_wr_en_i   (alu_wr_en),
    .alu_wr_reg_i  (alu_wr_reg),
    .alu_wr_data_i (alu_wr_data),
    .ld_wr_en_i    (ld_wr_en),
    .ld_wr_reg_i   (ld_wr_reg),
    .ld_wr_data_i  (ld_wr_data)
  );

  alu_stage u_alu_stage (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .valid_i              (ex_valid),
    .mem_stall_i          (mem_stall),
    .data_a_i             (ex_rs1_data),
    .data_b_i             (ex_rs2_data),
    .pc_i                 (ex_pc),
    .offset_sign_extend_i (ex_imm),
    .instruction_i        (ex_instr),
    .alu_wr_en_o          (alu_wr_en),
    .wr_reg_o             (alu_wr_reg),
    .data_to_reg_o        (alu_wr_data),
    .branch_taken_o       (branch_taken_o),
    .pc_branch_offset_o   (branch_target_o),
    .is_jump_o            (is_jump_o),
    .jump_address_o       (jump_target_o),
    .mem_valid_o          (mem_valid),
    .mem_is_load_o        (mem_is_load),
    .mem_is_store_o       (mem_is_store),
    .mem_access_size_o    (mem_access_size),
    .mem_alu_result_o     (mem_alu_result),
    .mem_rs2_data_o       (mem_rs2_data),
    .mem_wr_reg_o         (mem_wr_reg)
  );

  mem_stage u_mem_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mem_valid_i   (mem_valid),
    .is_load_i     (mem_is_load),
    .is_store_i    (mem_is_store),
    .access_size_i (mem_access_size),
    .addr_i        (mem_alu_result),
    .store_data_i  (mem_rs2_data),
    .wr_reg_i      (mem_wr_reg),
    .mem_stall_o   (mem_stall),
    .ld_wr_en_o    (ld_wr_en),
    .ld_wr_reg_o   (ld_wr_reg),
    .ld_wr_data_o  (ld_wr_data)
  );

endmodule : exec_core

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period.
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // active low for the first 10 cycles.
  initial begin
    rst_o = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire

//--- verification/exec_core_tb.sv
`default_nettype none
`include "core_defines.svh"

module exec_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [2:0] F_ADD  = 3'b000;
  localparam logic [2:0] F_SLL  = 3'b001;
  localparam logic [2:0] F_SLT  = 3'b010;
  localparam logic [2:0] F_SLTU = 3'b011;
  localparam logic [2:0] F_XOR  = 3'b100;
  localparam logic [2:0] F_SR   = 3'b101;
  localparam logic [2:0] F_OR   = 3'b110;
  localparam logic [2:0] F_AND  = 3'b111;
  localparam logic [2:0] F_BEQ  = 3'b000;
  localparam logic [2:0] F_BNE  = 3'b001;
  localparam logic [2:0] F_BLT  = 3'b100;
  localparam logic [2:0] F_BGE  = 3'b101;
  localparam logic [2:0] F_BYTE = 3'b000;
  localparam logic [2:0] F_WORD = 3'b010;
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;
  localparam int KIND_NONE   = 0;
  localparam int KIND_REG    = 1;
  localparam int KIND_BRANCH = 2;
  localparam int READY_TIMEOUT = 20;
  localparam int RESET_TIMEOUT = 50;

  logic                       clk;
  logic                       rst;
  logic                       issue_valid;
  logic [`DATA_WIDTH-1:0]     issue_instr;
  logic [`ADDR_WIDTH-1:0]     issue_pc;
  logic                       ready;
  logic                       branch_taken;
  logic [`ADDR_WIDTH-1:0]     branch_target;
  logic                       is_jump;
  logic [`ADDR_WIDTH-1:0]     jump_target;
  logic [`REG_ADDR_WIDTH-1:0] dbg_addr;
  logic [`DATA_WIDTH-1:0]     dbg_data;

  // stimulus table, one column per queue.
  string       t_name[$];
  logic [31:0] t_instr[$];
  logic [31:0] t_pc[$];
  int          t_kind[$];
  int          t_reg[$];
  logic [31:0] t_exp[$];
  logic        t_taken[$];
  logic        t_jump[$];
  logic [31:0] t_target[$];
  logic [31:0] t_shadow[$];

  int          errors;
  logic [31:0] rng_state;
  logic [31:0] row_pc;

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  exec_core u_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .issue_valid_i  (issue_valid),
    .issue_instr_i  (issue_instr),
    .issue_pc_i     (issue_pc),
    .ready_o        (ready),
    .branch_taken_o (branch_taken),
    .branch_target_o(branch_target),
    .is_jump_o      (is_jump),
    .jump_target_o  (jump_target),
    .dbg_reg_addr_i (dbg_addr),
    .dbg_reg_data_o (dbg_data)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_R};
  endfunction

  function automatic logic [31:0] i_word(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_word(input int imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] b_word(input int off, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_word(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input int rd);
    return {imm, rd[4:0], OP_AUIPC};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s expected %h actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("timed out while waiting for %s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic table_row(input string name, input logic [31:0] instr, input int kind,
                           input int rd, input logic [31:0] exp, input logic taken,
                           input logic jump, input logic [31:0] target,
                           input logic [31:0] shadow);
    t_name.push_back(name);
    t_instr.push_back(instr);
    t_pc.push_back(row_pc);
    t_kind.push_back(kind);
    t_reg.push_back(rd);
    t_exp.push_back(exp);
    t_taken.push_back(taken);
    t_jump.push_back(jump);
    t_target.push_back(target);
    t_shadow.push_back(shadow);
    row_pc = row_pc + 4;
  endtask

  task automatic expect_reg(input string name, input logic [31:0] instr, input int rd,
                            input logic [31:0] exp);
    table_row(name, instr, KIND_REG, rd, exp, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic plain_row(input string name, input logic [31:0] instr);
    table_row(name, instr, KIND_NONE, 0, '0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic branch_row(input string name, input logic [2:0] f3, input int rs1,
                            input int rs2, input int off, input logic taken);
    table_row(name, b_word(off, rs2, rs1, f3), KIND_BRANCH, 0, '0, taken, 1'b0,
              row_pc + off, '0);
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rnd [3];
    a = 100;
    b = -7;
    row_pc = 32'h100;
    expect_reg("addi_pos", i_word(100, 0, F_ADD, 1, OP_IMM), 1, a);
    expect_reg("addi_neg", i_word(-7, 0, F_ADD, 2, OP_IMM), 2, b);
    expect_reg("addi_shamt", i_word(3, 0, F_ADD, 6, OP_IMM), 6, 3);
    expect_reg("add", r_word(F7_BASE, 2, 1, F_ADD, 3), 3, a + b);
    expect_reg("sub", r_word(F7_ALT, 2, 1, F_ADD, 4), 4, a - b);
    expect_reg("and", r_word(F7_BASE, 2, 1, F_AND, 5), 5, a & b);
    expect_reg("or", r_word(F7_BASE, 2, 1, F_OR, 7), 7, a | b);
    expect_reg("xor", r_word(F7_BASE, 2, 1, F_XOR, 8), 8, a ^ b);
    expect_reg("sll", r_word(F7_BASE, 6, 1, F_SLL, 9), 9, a << 3);
    expect_reg("srl", r_word(F7_BASE, 6, 2, F_SR, 10), 10, b >> 3);
    expect_reg("sra", r_word(F7_ALT, 6, 2, F_SR, 11), 11, $signed(b) >>> 3);
    expect_reg("slt", r_word(F7_BASE, 1, 2, F_SLT, 12), 12, 32'($signed(b) < $signed(a)));
    expect_reg("sltu", r_word(F7_BASE, 1, 2, F_SLTU, 13), 13, 32'(b < a));
    expect_reg("slli", i_word(4, 1, F_SLL, 14, OP_IMM), 14, a << 4);
    expect_reg("srai", i_word(32'h401, 2, F_SR, 15, OP_IMM), 15, $signed(b) >>> 1);
    expect_reg("xori", i_word(-1, 1, F_XOR, 16, OP_IMM), 16, ~a);
    expect_reg("sltiu", i_word(-1, 1, F_SLTU, 17, OP_IMM), 17, 1);
    expect_reg("andi", i_word(32'hf0, 1, F_AND, 18, OP_IMM), 18, a & 32'hf0);
    expect_reg("addi_x0", i_word(5, 0, F_ADD, 0, OP_IMM), 0, '0);
    // random immediates, sign extended from 12 bits.
    for (int k = 0; k < 3; k++) begin
      rng_state = xorshift(rng_state);
      rnd[k] = {{20{rng_state[11]}}, rng_state[11:0]};
      expect_reg($sformatf("addi_rand%0d", k), i_word(rnd[k], 0, F_ADD, 19 + k, OP_IMM),
                 19 + k, rnd[k]);
    end
    expect_reg("add_rand01", r_word(F7_BASE, 20, 19, F_ADD, 22), 22, rnd[0] + rnd[1]);
    expect_reg("add_rand012", r_word(F7_BASE, 21, 22, F_ADD, 22), 22,
               rnd[0] + rnd[1] + rnd[2]);
    // data memory around address 64.
    expect_reg("addi_base", i_word(64, 0, F_ADD, 23, OP_IMM), 23, 64);
    plain_row("sw_neg", s_word(0, 2, 23, F_WORD));
    expect_reg("lw_neg", i_word(0, 23, F_WORD, 24, OP_LOAD), 24, b);
    expect_reg("lb_top", i_word(3, 23, F_BYTE, 25, OP_LOAD), 25, {{24{b[31]}}, b[31:24]});
    plain_row("sw_pos", s_word(4, 1, 23, F_WORD));
    plain_row("sb_lane1", s_word(5, 2, 23, F_BYTE));
    plain_row("sb_lane2", s_word(6, 1, 23, F_BYTE));
    expect_reg("lw_merged", i_word(4, 23, F_WORD, 26, OP_LOAD), 26,
               {a[31:24], a[7:0], b[7:0], a[7:0]});
    expect_reg("lb_lane1", i_word(5, 23, F_BYTE, 27, OP_LOAD), 27, {{24{b[7]}}, b[7:0]});
    expect_reg("lb_lane2", i_word(6, 23, F_BYTE, 28, OP_LOAD), 28, {{24{a[7]}}, a[7:0]});
    // branches on x1 = 100 and x2 = -7.
    branch_row("beq_taken", F_BEQ, 1, 1, 16, 1'b1);
    branch_row("beq_not", F_BEQ, 1, 2, 16, 1'b0);
    branch_row("bne_taken", F_BNE, 1, 2, -32, 1'b1);
    branch_row("bne_not", F_BNE, 2, 2, -32, 1'b0);
    branch_row("blt_taken", F_BLT, 2, 1, 64, 1'b1);
    branch_row("blt_not", F_BLT, 1, 2, 64, 1'b0);
    branch_row("bge_taken", F_BGE, 1, 2, -8, 1'b1);
    branch_row("bge_not", F_BGE, 2, 1, -8, 1'b0);
    branch_row("bge_equal", F_BGE, 1, 1, 24, 1'b1);
    // the word offered in the redirect cycle must be dropped.
    table_row("beq_drop", b_word(8, 1, 1, F_BEQ), KIND_REG, 29, '0, 1'b1, 1'b0,
              row_pc + 8, i_word(55, 0, F_ADD, 29, OP_IMM));
    table_row("jal_fwd", j_word(2048, 30), KIND_REG, 30, row_pc + 4, 1'b0, 1'b1,
              row_pc + 2048, i_word(77, 0, F_ADD, 31, OP_IMM));
    expect_reg("jal_drop", i_word(0, 0, F_ADD, 0, OP_IMM), 31, '0);
    table_row("jal_back", j_word(-12, 1), KIND_REG, 1, row_pc + 4, 1'b0, 1'b1,
              row_pc - 12, '0);
    expect_reg("auipc", u_word(20'h12345, 5), 5, 32'h1234_5000 + row_pc);
    expect_reg("auipc_neg", u_word(20'hfffff, 6), 6, row_pc - 32'h1000);
  endtask

  // redirect outputs are checked on every row.
  task automatic run_entry(input int idx);
    int          waited;
    int          low_cycles;
    logic        seen_taken;
    logic        seen_jump;
    logic [31:0] seen_branch_target;
    logic [31:0] seen_jump_target;
    logic [31:0] expected_low;
    waited = 0;
    low_cycles = 0;
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_instr <= t_instr[idx];
    issue_pc    <= t_pc[idx];
    dbg_addr    <= t_reg[idx][4:0];
    @(negedge clk);
    while (!ready) begin
      waited++;
      if (waited > READY_TIMEOUT) begin
        timeout_fail("ready_o before issue");
      end
      @(negedge clk);
    end
    // acceptance edge.
    @(posedge clk);
    issue_valid <= (t_shadow[idx] != '0);
    issue_instr <= t_shadow[idx];
    issue_pc    <= t_pc[idx] + 4;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      if (!ready) begin
        low_cycles++;
      end
      if (c == 0) begin
        seen_taken         = branch_taken;
        seen_jump          = is_jump;
        seen_branch_target = branch_target;
        seen_jump_target   = jump_target;
      end
      @(posedge clk);
      issue_valid <= 1'b0;
    end
    @(negedge clk);
    expected_low = (t_instr[idx][6:0] == OP_LOAD) ? 32'd1 : 32'd0;
    check_value($sformatf("%s stall", t_name[idx]), expected_low, low_cycles);
    check_value($sformatf("%s taken", t_name[idx]), 32'(t_taken[idx]), 32'(seen_taken));
    check_value($sformatf("%s jump", t_name[idx]), 32'(t_jump[idx]), 32'(seen_jump));
    if (t_taken[idx]) begin
      check_value($sformatf("%s target", t_name[idx]), t_target[idx], seen_branch_target);
    end
    if (t_jump[idx]) begin
      check_value($sformatf("%s target", t_name[idx]), t_target[idx], seen_jump_target);
    end
    if (t_kind[idx] == KIND_REG) begin
      check_value($sformatf("%s x%0d", t_name[idx], t_reg[idx]), t_exp[idx], dbg_data);
    end
  endtask

  initial begin
    int waited;
    errors      = 0;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_pc    = '0;
    dbg_addr    = '0;
    rng_state   = 32'd63;
    build_table();
    waited = 0;
    while (rst !== 1'b1) begin
      waited++;
      if (waited > RESET_TIMEOUT) begin
        timeout_fail("reset release");
      end
      @(posedge clk);
    end
    @(negedge clk);
    check_value("reset ready", 32'd1, 32'(ready));
    for (int r = 1; r < 32; r += 10) begin
      @(posedge clk);
      dbg_addr <= 5'(r);
      @(negedge clk);
      check_value($sformatf("reset x%0d", r), '0, dbg_data);
    end
    for (int i = 0; i < t_name.size(); i++) begin
      run_entry(i);
    end
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : exec_core_tb

`default_nettype wire

//--- compile.f
+incdir+logic
logic/core_pkg.sv
logic/alu.sv
logic/alu_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/mem_stage.sv
logic/exec_core.sv
verification/tb_clock_gen.sv
verification/exec_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exec_core testbench, then scan the log.
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module exec_core_tb -o exec_core_sim > sim.log 2>&1 \
  && ./obj_dir/exec_core_sim >> sim.log 2>&1 \
  || echo "TESTBENCH FAILED" >> sim.log
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
exit 0
